// ==== mm_trg_cfg.svh ====
`ifndef MM_TRG_CFG_SVH
`define MM_TRG_CFG_SVH

// rf data converter stream width
`define MM_TDATA_W 128

// samples carried in one beat
`define MM_LANES 8

// adc resolution, sample sits in the upper bits of its lane
`define MM_ADC_W 12

// lanes that must all pass the compare for a hit
`define MM_HIT_WIN 8

// longest trigger window in beats
`define MM_ACQ_LEN 100

// beats without hit before the window closes early
`define MM_POST_LEN 38

// width of the pre-acquisition run length
`define MM_PRE_W 5

// time stamp width
`define MM_TS_W 48

// input beat to output beat
`define MM_ALIGN_LAT 3

`endif

// ==== mm_trg_pkg.sv ====
`include "mm_trg_cfg.svh"

package mm_trg_pkg;

  // trigger controller states
  typedef enum logic [1:0] {
    WAIT_RUN,
    ARMED,
    CAPTURE
  } trg_state_e;

  // raw adc sample
  typedef logic signed [`MM_ADC_W-1:0] sample_t;

  // one bit of growth for sample minus baseline
  typedef logic signed [`MM_ADC_W:0] thresh_t;

endpackage

// ==== trg_if.sv ====
`include "mm_trg_cfg.svh"

interface trg_if;

  // aligned beat and its valid
  logic [`MM_TDATA_W-1:0] data;
  logic                   valid;
  // pre-acquisition run reached
  logic                   run_ok;
  // detection window pass
  logic                   hit;

  modport det (
    output hit
  );

  modport align (
    output data,
    output valid,
    output run_ok
  );

  modport ctrl (
    input data,
    input valid,
    input run_ok,
    input hit
  );

endinterface

// ==== hit_detector.sv ====
`include "mm_trg_cfg.svh"

module hit_detector (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [`MM_TDATA_W-1:0] tdata,
  input  logic                   tvalid,
  input  mm_trg_pkg::sample_t    baseline,
  input  mm_trg_pkg::thresh_t    threshold,
  trg_if.det                     trg
);

  localparam int LANE_W = `MM_TDATA_W / `MM_LANES;
  localparam int N_WIN  = `MM_LANES / `MM_HIT_WIN;

  logic [`MM_LANES-1:0] cmp_d;
  logic [`MM_LANES-1:0] cmp_q;
  logic                 hit_d;

  // per-lane compare of sample minus baseline
  always_comb begin
    mm_trg_pkg::sample_t smp;
    mm_trg_pkg::thresh_t delta;
    for (int i = 0; i < `MM_LANES; i++) begin
      smp      = tdata[LANE_W*i + LANE_W-1 -: `MM_ADC_W];
      // operands widen to 13 bits before the subtract
      delta    = smp - baseline;
      cmp_d[i] = (delta >= threshold);
    end
  end

  // an idle beat never counts
  always_ff @(posedge clk) begin
    if (!resetn || !tvalid) begin
      cmp_q <= '0;
    end else begin
      cmp_q <= cmp_d;
    end
  end

  // all lanes of a window pass, any window will do
  always_comb begin
    hit_d = 1'b0;
    for (int w = 0; w < N_WIN; w++) begin
      hit_d = hit_d | (&cmp_q[w*`MM_HIT_WIN +: `MM_HIT_WIN]);
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      trg.hit <= 1'b0;
    end else begin
      trg.hit <= hit_d;
    end
  end

endmodule

// ==== sample_aligner.sv ====
`include "mm_trg_cfg.svh"

module sample_aligner (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [`MM_TDATA_W-1:0] tdata,
  input  logic                   tvalid,
  input  logic [`MM_PRE_W-1:0]   pre_len,
  trg_if.align                   trg
);

  localparam int LANE_W = `MM_TDATA_W / `MM_LANES;

  logic [`MM_TDATA_W-1:0]  stg1_data;
  logic [`MM_TDATA_W-1:0]  stg2_data;
  logic [`MM_TDATA_W-1:0]  repacked;
  logic [`MM_ALIGN_LAT-1:0] vld_sr;
  logic [`MM_PRE_W-1:0]    pre_cnt;

  // sample moved to the low bits of its lane, upper bits zero
  always_comb begin
    for (int i = 0; i < `MM_LANES; i++) begin
      repacked[LANE_W*i +: LANE_W] =
        {{(LANE_W-`MM_ADC_W){1'b0}}, stg1_data[LANE_W*i + LANE_W-1 -: `MM_ADC_W]};
    end
  end

  // three data stages, repack between the first and second
  always_ff @(posedge clk) begin
    if (!resetn) begin
      stg1_data <= '1;
      stg2_data <= '1;
      trg.data  <= '1;
    end else begin
      stg1_data <= tdata;
      stg2_data <= repacked;
      trg.data  <= stg2_data;
    end
  end

  // valid follows the data through the same number of stages
  always_ff @(posedge clk) begin
    if (!resetn) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[`MM_ALIGN_LAT-2:0], tvalid};
    end
  end

  assign trg.valid = vld_sr[`MM_ALIGN_LAT-1];

  // consecutive valid beats, restart on a gap
  // run_ok sticks until the next reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pre_cnt    <= '0;
      trg.run_ok <= 1'b0;
    end else if (!trg.run_ok) begin
      if (!tvalid) begin
        pre_cnt <= '0;
      end else if (pre_cnt == pre_len - `MM_PRE_W'd1) begin
        trg.run_ok <= 1'b1;
      end else begin
        pre_cnt <= pre_cnt + `MM_PRE_W'd1;
      end
    end
  end

endmodule

// ==== trigger_ctrl.sv ====
`include "mm_trg_cfg.svh"

module trigger_ctrl (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      all_module_ready,
  input  logic                      tvalid,
  input  logic [`MM_TS_W-1:0]       cur_time,
  input  mm_trg_pkg::sample_t       baseline,
  input  mm_trg_pkg::thresh_t       threshold,
  trg_if.ctrl                       trg,
  output logic                      triggered,
  output logic [`MM_TS_W-1:0]       time_stamp,
  output mm_trg_pkg::sample_t       baseline_hit,
  output mm_trg_pkg::thresh_t       threshold_hit
);

  localparam int ACQ_W  = $clog2(`MM_ACQ_LEN + 1);
  localparam int POST_W = $clog2(`MM_POST_LEN);

  mm_trg_pkg::trg_state_e state;
  mm_trg_pkg::trg_state_e state_nx;

  logic              ready_q;
  logic [ACQ_W-1:0]  acq_cnt;
  logic [POST_W-1:0] post_cnt;
  logic              start;
  logic              acq_done;
  logic              post_done;

  // any drop of the ready terms aborts one edge later
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= tvalid & all_module_ready & trg.run_ok;
    end
  end

  assign start     = ready_q && (state == mm_trg_pkg::ARMED) && trg.hit;
  assign acq_done  = (acq_cnt == ACQ_W'(`MM_ACQ_LEN));
  assign post_done = !trg.hit && (post_cnt == POST_W'(`MM_POST_LEN - 1));

  always_comb begin
    state_nx = state;
    case (state)
      mm_trg_pkg::WAIT_RUN: state_nx = mm_trg_pkg::ARMED;
      mm_trg_pkg::ARMED: begin
        if (trg.hit) begin
          state_nx = mm_trg_pkg::CAPTURE;
        end
      end
      mm_trg_pkg::CAPTURE: begin
        if (acq_done || post_done) begin
          state_nx = mm_trg_pkg::ARMED;
        end
      end
      default: state_nx = mm_trg_pkg::WAIT_RUN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn || !ready_q) begin
      state <= mm_trg_pkg::WAIT_RUN;
    end else begin
      state <= state_nx;
    end
  end

  // window length counters, first beat of the window counts as one
  always_ff @(posedge clk) begin
    if (!resetn) begin
      acq_cnt  <= '0;
      post_cnt <= '0;
    end else if (start) begin
      acq_cnt  <= ACQ_W'(1);
      post_cnt <= '0;
    end else if (state == mm_trg_pkg::CAPTURE) begin
      acq_cnt <= acq_cnt + ACQ_W'(1);
      // restart on every hit beat
      if (trg.hit) begin
        post_cnt <= '0;
      end else begin
        post_cnt <= post_cnt + POST_W'(1);
      end
    end
  end

  // snapshot on the edge the window opens
  always_ff @(posedge clk) begin
    if (!resetn) begin
      time_stamp    <= '0;
      baseline_hit  <= baseline;
      threshold_hit <= threshold;
    end else if (start) begin
      time_stamp    <= cur_time;
      baseline_hit  <= baseline;
      threshold_hit <= threshold;
    end
  end

  assign triggered = (state == mm_trg_pkg::CAPTURE);

endmodule

// ==== mm_trg_top.sv ====
`include "mm_trg_cfg.svh"

module mm_trg_top (
  input  logic                   CLK,
  input  logic                   RESETN,
  input  logic [`MM_TDATA_W-1:0] TDATA,
  input  logic                   TVALID,
  input  logic                   ALL_MODULE_READY,
  input  logic [`MM_PRE_W-1:0]   PRE_ACQ_LEN,
  input  mm_trg_pkg::thresh_t    THRESHOLD_VAL,
  input  mm_trg_pkg::sample_t    BASELINE,
  input  logic [`MM_TS_W-1:0]    CURRENT_TIME,
  output logic [`MM_TS_W-1:0]    TIME_STAMP,
  output mm_trg_pkg::sample_t    BASELINE_WHEN_HIT,
  output mm_trg_pkg::thresh_t    THRESHOLD_WHEN_HIT,
  output logic                   TRIGGERED,
  output logic [`MM_TDATA_W-1:0] DATA,
  output logic                   VALID
);

  logic [`MM_PRE_W-1:0] pre_len_q;
  mm_trg_pkg::sample_t  baseline_q;
  mm_trg_pkg::thresh_t  threshold_q;

  trg_if trg_bus ();

  // configuration follows the inputs while in reset, then holds
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      pre_len_q   <= PRE_ACQ_LEN;
      baseline_q  <= BASELINE;
      threshold_q <= THRESHOLD_VAL;
    end
  end

  hit_detector u_hit (
    .clk       (CLK),
    .resetn    (RESETN),
    .tdata     (TDATA),
    .tvalid    (TVALID),
    .baseline  (baseline_q),
    .threshold (threshold_q),
    .trg       (trg_bus.det)
  );

  sample_aligner u_align (
    .clk     (CLK),
    .resetn  (RESETN),
    .tdata   (TDATA),
    .tvalid  (TVALID),
    .pre_len (pre_len_q),
    .trg     (trg_bus.align)
  );

  trigger_ctrl u_ctrl (
    .clk              (CLK),
    .resetn           (RESETN),
    .all_module_ready (ALL_MODULE_READY),
    .tvalid           (TVALID),
    .cur_time         (CURRENT_TIME),
    .baseline         (baseline_q),
    .threshold        (threshold_q),
    .trg              (trg_bus.ctrl),
    .triggered        (TRIGGERED),
    .time_stamp       (TIME_STAMP),
    .baseline_hit     (BASELINE_WHEN_HIT),
    .threshold_hit    (THRESHOLD_WHEN_HIT)
  );

  // aligned stream leaves from the aligner stages
  assign DATA  = trg_bus.data;
  assign VALID = trg_bus.valid;

endmodule

// ==== tb_mm_trg.sv ====
`include "mm_trg_cfg.svh"

module tb_mm_trg;

  localparam int LANE_W   = `MM_TDATA_W / `MM_LANES;
  // lowest passing sample, baseline 100 plus threshold 200
  localparam int PASS_MIN = 300;
  localparam mm_trg_pkg::sample_t BASE_VAL = 12'sd100;
  localparam mm_trg_pkg::thresh_t THR_VAL  = 13'sd200;

  logic                   clk;
  logic                   resetn;
  logic [`MM_TDATA_W-1:0] tdata;
  logic                   tvalid;
  logic                   all_module_ready;
  logic [`MM_PRE_W-1:0]   pre_acq_len;
  mm_trg_pkg::thresh_t    threshold_val;
  mm_trg_pkg::sample_t    baseline;
  logic [`MM_TS_W-1:0]    current_time;
  logic [`MM_TS_W-1:0]    time_stamp;
  mm_trg_pkg::sample_t    baseline_when_hit;
  mm_trg_pkg::thresh_t    threshold_when_hit;
  logic                   triggered;
  logic [`MM_TDATA_W-1:0] data;
  logic                   valid;
  // time value seen by the DUT at the last rising edge
  logic [`MM_TS_W-1:0]    edge_time;
  integer                 seed;
  int                     err_count;
  int                     tests_run;
  int                     tests_failed;

  mm_trg_top dut0 (
    .CLK                (clk),
    .RESETN             (resetn),
    .TDATA              (tdata),
    .TVALID             (tvalid),
    .ALL_MODULE_READY   (all_module_ready),
    .PRE_ACQ_LEN        (pre_acq_len),
    .THRESHOLD_VAL      (threshold_val),
    .BASELINE           (baseline),
    .CURRENT_TIME       (current_time),
    .TIME_STAMP         (time_stamp),
    .BASELINE_WHEN_HIT  (baseline_when_hit),
    .THRESHOLD_WHEN_HIT (threshold_when_hit),
    .TRIGGERED          (triggered),
    .DATA               (data),
    .VALID              (valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // random beat, lanes set in pass_mask clear baseline plus threshold
  function automatic logic [`MM_TDATA_W-1:0] make_beat(input logic [`MM_LANES-1:0] pass_mask);
    logic [`MM_TDATA_W-1:0] beat;
    logic [31:0]            r;
    logic [31:0]            smp;
    for (int i = 0; i < `MM_LANES; i++) begin
      r = $random(seed);
      if (pass_mask[i]) smp = PASS_MIN + (r & 32'd1023);
      else smp = PASS_MIN - 1 - (r & 32'd2047);
      // sample in the upper 12 bits, noise below
      beat[LANE_W*i +: LANE_W] = {smp[`MM_ADC_W-1:0], r[15:12]};
    end
    return beat;
  endfunction

  function automatic logic [`MM_TDATA_W-1:0] const_beat(input int smp);
    logic [`MM_TDATA_W-1:0] beat;
    for (int i = 0; i < `MM_LANES; i++) beat[LANE_W*i +: LANE_W] = {smp[`MM_ADC_W-1:0], 4'h9};
    return beat;
  endfunction

  // expected output lane, sample zero-extended into the low bits
  function automatic logic [`MM_TDATA_W-1:0] repack(input logic [`MM_TDATA_W-1:0] beat);
    logic [`MM_TDATA_W-1:0] res;
    logic [LANE_W-1:0]      lane;
    for (int i = 0; i < `MM_LANES; i++) begin
      lane = beat[LANE_W*i +: LANE_W];
      // noise bits below the sample drop out
      res[LANE_W*i +: LANE_W] = lane >> (LANE_W - `MM_ADC_W);
    end
    return res;
  endfunction

  task automatic step();
    @(posedge clk);
    edge_time = current_time;
    #1;
    current_time = current_time + 1'b1;
  endtask

  task automatic drive_beat(input logic [`MM_TDATA_W-1:0] beat, input logic vld);
    tdata  = beat;
    tvalid = vld;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    err_count++;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    err_count++;
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    tests_run++;
    if (err_count != errs_at_start) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  task automatic apply_reset();
    resetn           = 1'b0;
    tvalid           = 1'b0;
    tdata            = '0;
    all_module_ready = 1'b1;
    baseline         = BASE_VAL;
    threshold_val    = THR_VAL;
    pre_acq_len      = 5'd4;
    repeat (4) step();
    if (triggered !== 1'b0 || valid !== 1'b0) report_error("TRIGGERED or VALID high in reset");
    if (data !== '1 || time_stamp !== '0) report_error("DATA or TIME_STAMP wrong in reset");
    if (baseline_when_hit !== BASE_VAL || threshold_when_hit !== THR_VAL)
      report_error("snapshots differ from configuration in reset");
    resetn        = 1'b1;
    // inputs move away, latched configuration must hold
    baseline      = -12'sd50;
    threshold_val = 13'sd5;
    pre_acq_len   = 5'd1;
  endtask

  // quiet valid beats until the window stays shut
  task automatic wait_idle();
    int cnt;
    int low_run;
    cnt     = 0;
    low_run = 0;
    while (low_run < 4 && cnt < 300) begin
      drive_beat(make_beat('0), 1'b1);
      step();
      cnt++;
      low_run = triggered ? 0 : low_run + 1;
    end
    if (low_run < 4) report_timeout("TRIGGERED did not stay low");
  endtask

  task automatic wait_rise(input logic [`MM_TDATA_W-1:0] hit_beat, output int cycles);
    drive_beat(hit_beat, 1'b1);
    cycles = 0;
    do begin
      step();
      cycles++;
      drive_beat(make_beat('0), 1'b1);
    end while (!triggered && cycles < 20);
    if (!triggered) report_timeout("TRIGGERED did not rise after a passing beat");
  endtask

  // one passing beat, then quiet or more passing beats until the window shuts
  task automatic measure_window(input logic keep_hitting, output int rise_at,
                                output int high_cnt, output logic done);
    int cnt;
    cnt      = 0;
    rise_at  = 0;
    high_cnt = 0;
    done     = 1'b0;
    drive_beat(make_beat('1), 1'b1);
    while (!done && cnt < 200) begin
      step();
      cnt++;
      if (triggered) begin
        if (high_cnt == 0) rise_at = cnt;
        high_cnt++;
      end else if (high_cnt > 0) begin
        done = 1'b1;
      end
      if (!done) drive_beat(keep_hitting ? make_beat('1) : make_beat('0), 1'b1);
    end
    if (!done) report_timeout("trigger window did not close");
  endtask

  task automatic test_data_path();
    logic [`MM_TDATA_W-1:0] beats [0:39];
    logic                   vlds [0:39];
    logic [`MM_LANES-1:0]   mask;
    logic [31:0]            r;
    int                     errs;
    errs = err_count;
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      mask = r[7:0];
      mask[r[10:8]] = 1'b0;
      beats[i] = make_beat(mask);
      vlds[i]  = (r[13:12] != 2'b00);
      drive_beat(beats[i], vlds[i]);
      step();
      if (i >= 2 && data !== repack(beats[i-2]))
        report_error($sformatf("DATA %h, expected %h", data, repack(beats[i-2])));
      if (i >= 2 && valid !== vlds[i-2]) report_error("VALID does not follow TVALID");
    end
    finish_test("data_path", errs);
  endtask

  task automatic test_no_trigger();
    logic [`MM_TDATA_W-1:0] beat;
    logic [`MM_LANES-1:0]   mask;
    int                     errs;
    errs = err_count;
    for (int i = 0; i < 44; i++) begin
      mask = '1;
      mask[i % `MM_LANES] = 1'b0;
      if (i < 10 || i >= 40) beat = make_beat('0);
      else if (i % 5 == 0) beat = const_beat(PASS_MIN - 1);
      else beat = make_beat(mask);
      drive_beat(beat, 1'b1);
      step();
      if (triggered !== 1'b0) report_error("TRIGGERED rose without a full window pass");
    end
    finish_test("no_trigger", errs);
  endtask

  task automatic test_trigger_capture();
    logic [`MM_TDATA_W-1:0] hit_beat;
    int                     cycles;
    int                     errs;
    errs = err_count;
    // every lane exactly at the threshold
    hit_beat = const_beat(PASS_MIN);
    wait_rise(hit_beat, cycles);
    if (triggered) begin
      if (cycles != 3) report_error($sformatf("TRIGGERED rose after %0d cycles", cycles));
      if (data !== repack(hit_beat) || valid !== 1'b1)
        report_error("DATA at trigger is not the passing beat");
      if (time_stamp !== edge_time)
        report_error($sformatf("TIME_STAMP %0d, expected %0d", time_stamp, edge_time));
      if (baseline_when_hit !== BASE_VAL) report_error("BASELINE_WHEN_HIT wrong");
      if (threshold_when_hit !== THR_VAL) report_error("THRESHOLD_WHEN_HIT wrong");
    end
    wait_idle();
    finish_test("trigger_capture", errs);
  endtask

  task automatic test_window_length();
    int   rise_at;
    int   high_cnt;
    logic done;
    int   errs;
    errs = err_count;
    measure_window(1'b0, rise_at, high_cnt, done);
    if (done && (rise_at != 3 || high_cnt != `MM_POST_LEN))
      report_error($sformatf("single hit: rise %0d, open %0d beats", rise_at, high_cnt));
    // re-trigger straight after the close
    measure_window(1'b1, rise_at, high_cnt, done);
    if (done && (rise_at != 3 || high_cnt != `MM_ACQ_LEN))
      report_error($sformatf("continuous hits: rise %0d, open %0d beats", rise_at, high_cnt));
    wait_idle();
    finish_test("window_length", errs);
  endtask

  task automatic test_abort_rearm();
    int cycles;
    int errs;
    errs = err_count;
    wait_rise(make_beat('1), cycles);
    repeat (3) begin
      step();
      if (!triggered) report_error("window closed before the abort");
    end
    all_module_ready = 1'b0;
    cycles = 0;
    do begin
      step();
      cycles++;
    end while (triggered && cycles < 10);
    if (triggered) report_timeout("TRIGGERED did not fall after ready dropped");
    else if (cycles != 2) report_error($sformatf("abort took %0d cycles", cycles));
    all_module_ready = 1'b1;
    // runs of three valid beats never arm with a pre length of four
    apply_reset();
    for (int i = 0; i < 12; i++) begin
      drive_beat((i == 2 || i == 6) ? make_beat('1) : make_beat('0), !(i == 3 || i >= 7));
      step();
      if (triggered !== 1'b0) report_error("TRIGGERED rose before the run completed");
    end
    repeat (8) begin
      drive_beat(make_beat('0), 1'b1);
      step();
    end
    wait_rise(make_beat('1), cycles);
    if (triggered && cycles != 3) report_error("re-armed trigger came late");
    wait_idle();
    finish_test("abort_rearm", errs);
  endtask

  initial begin
    seed         = 32'h6f45_3f52;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    current_time = '0;
    edge_time    = '0;
    apply_reset();
    test_data_path();
    test_no_trigger();
    test_trigger_capture();
    test_window_length();
    test_abort_rearm();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== mm_trg_top.f ====
+incdir+.
mm_trg_pkg.sv
trg_if.sv
hit_detector.sv
sample_aligner.sv
trigger_ctrl.sv
mm_trg_top.sv
tb_mm_trg.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
log_file=sim.log

if ! rm -rf obj_dir; then
  echo "could not clean obj_dir"
  exit 1
fi

if ! verilator --binary --timing -Wno-fatal --top-module tb_mm_trg \
    -f mm_trg_top.f -o tb_mm_trg; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mm_trg > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "PASS: all tests" "$log_file"; then
  exit 0
fi
echo "simulation reported failure"
exit 1
